//--- csr_unit.f
csr_pkg.sv
csr_file.sv
csr_alu.sv
trap_ctrl.sv
csr_unit.sv
csr_unit_checker.sv
csr_unit_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := csr_unit_tb
FILELIST   := csr_unit.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing --assert -j 0 --top-module $(TOP) -Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only -Wall --timing --assert --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- csr_unit_tb.sv
// Directed testbench for the machine-mode CSR unit with trap and interrupt scenarios
`timescale 1ns/1ns

module csr_unit_tb
  import csr_pkg::*;
();

  localparam int          timeout_cycles = 2000; // Tests need a few hundred cycles at most
  localparam logic [63:0] misa_expect    = {2'b10, 53'b0, 1'b1, 8'b0}; // MXL=2, I

  logic        clk;
  logic        rst;
  csr_req_t    csr_req;
  trap_req_t   trap_req;
  logic        mret;
  logic        commit;
  logic [63:0] pc;
  logic        irq_soft;
  logic        irq_timer;
  logic        irq_ext;
  logic [63:0] rd_data;
  logic        csr_illegal;
  logic        redirect_valid;
  logic [63:0] redirect_pc;

  logic [31:0] lfsr_state;
  int          cycle_count = 0;
  logic [63:0] got_rd;
  logic [63:0] got_illegal;
  logic [63:0] got_redirect;
  logic [63:0] got_target;

  csr_unit uut (
    .clk            (clk),
    .rst            (rst),
    .csr_req        (csr_req),
    .trap_req       (trap_req),
    .mret           (mret),
    .commit         (commit),
    .pc             (pc),
    .irq_soft       (irq_soft),
    .irq_timer      (irq_timer),
    .irq_ext        (irq_ext),
    .rd_data        (rd_data),
    .csr_illegal    (csr_illegal),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("The run did not finish within %0d cycles", timeout_cycles);
      $display("Test failed");
      $fatal(1, "Timeout");
    end
  end

  // Galois LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic draw_bits(input int n, output logic [63:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value      = {value[62:0], lfsr_state[0]};
    end
  endtask

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERROR %s: got %h, expected %h", name, got, exp);
      $display("Test failed");
      $fatal(1, "Value mismatch on %s", name);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #10;
  endtask

  task automatic set_req(input csr_op_e op, input logic [11:0] addr, input logic [63:0] src,
                         input logic x0);
    csr_req.valid     = 1'b1;
    csr_req.op        = op;
    csr_req.addr      = addr;
    csr_req.src       = src;
    csr_req.src_is_x0 = x0;
  endtask

  // Sample outputs mid-cycle, then drop the strobes after the edge
  task automatic run_cycle();
    #40;
    got_rd       = rd_data;
    got_illegal  = 64'(csr_illegal);
    got_redirect = 64'(redirect_valid);
    got_target   = redirect_pc;
    next_cycle();
    csr_req  = '0;
    trap_req = '0;
    mret     = 1'b0;
    commit   = 1'b0;
  endtask

  task automatic csr_write(input logic [11:0] addr, input logic [63:0] value);
    set_req(op_rw, addr, value, 1'b0);
    run_cycle();
    check_value("csr_illegal", got_illegal, 64'd0);
  endtask

  task automatic expect_read(input string name, input logic [11:0] addr, input logic [63:0] exp);
    set_req(op_rs, addr, 64'd0, 1'b1); // csrrs rd, csr, x0
    run_cycle();
    check_value("csr_illegal", got_illegal, 64'd0);
    check_value(name, got_rd, exp);
  endtask

  task automatic test_reset_values();
    expect_read("mstatus", addr_mstatus, 64'h1880);
    expect_read("misa", addr_misa, misa_expect);
    expect_read("mie", addr_mie, '0);
    expect_read("mtvec", addr_mtvec, '0);
    expect_read("mscratch", addr_mscratch, '0);
    expect_read("mepc", addr_mepc, '0);
    expect_read("mcause", addr_mcause, '0);
    expect_read("mtval", addr_mtval, '0);
    expect_read("mvendorid", addr_mvendorid, '0);
    expect_read("marchid", addr_marchid, '0);
    expect_read("mimpid", addr_mimpid, '0);
    expect_read("mhartid", addr_mhartid, '0);
    set_req(op_rw, addr_misa, 64'd0, 1'b0);
    run_cycle();
    check_value("csr_illegal", got_illegal, 64'd1);
    expect_read("misa", addr_misa, misa_expect);
    set_req(op_rw, addr_mhartid, 64'd5, 1'b0);
    run_cycle();
    check_value("csr_illegal", got_illegal, 64'd1);
    expect_read("mhartid", addr_mhartid, '0);
    set_req(op_rs, 12'h7c0, 64'd0, 1'b1); // Not a machine CSR
    run_cycle();
    check_value("csr_illegal", got_illegal, 64'd1);
  endtask

  // Register starts at zero after reset
  task automatic exercise_reg(input string name, input logic [11:0] addr, input logic [63:0] mask);
    logic [63:0] model;
    logic [63:0] src;
    model = '0;
    draw_bits(64, src);
    set_req(op_rw, addr, src, 1'b0);
    run_cycle();
    check_value(name, got_rd, model);
    model = (model & ~mask) | (src & mask);
    draw_bits(64, src);
    set_req(op_rs, addr, src, 1'b0);
    run_cycle();
    check_value(name, got_rd, model);
    model = (model & ~mask) | ((model | src) & mask);
    draw_bits(64, src);
    set_req(op_rc, addr, src, 1'b0);
    run_cycle();
    check_value(name, got_rd, model);
    model = (model & ~mask) | ((model & ~src) & mask);
    expect_read(name, addr, model);
    draw_bits(64, src);
    set_req(op_rs, addr, src, 1'b1);
    run_cycle();
    set_req(op_rc, addr, src, 1'b1);
    run_cycle();
    expect_read(name, addr, model); // x0 source never writes
  endtask

  task automatic test_exception();
    logic [63:0] base;
    logic [63:0] cause;
    logic [63:0] tval;
    logic [63:0] epc;
    logic [63:0] scratch;
    logic [63:0] junk;
    draw_bits(64, base);
    base[1:0] = 2'b00; // Direct mode
    csr_write(addr_mtvec, base);
    csr_write(addr_mstatus, 64'h8);
    draw_bits(64, scratch);
    csr_write(addr_mscratch, scratch);
    draw_bits(64, cause);
    draw_bits(64, tval);
    draw_bits(64, epc);
    draw_bits(64, junk);
    trap_req = '{valid: 1'b1, cause: cause, tval: tval};
    pc       = epc;
    set_req(op_rw, addr_mscratch, junk, 1'b0);
    run_cycle();
    check_value("redirect_valid", got_redirect, 64'd1);
    check_value("redirect_pc", got_target, base);
    check_value("rd_data", got_rd, scratch);
    expect_read("mepc", addr_mepc, {epc[63:2], 2'b00});
    check_value("redirect_valid", got_redirect, 64'd0);
    expect_read("mcause", addr_mcause, cause);
    expect_read("mtval", addr_mtval, tval);
    expect_read("mstatus", addr_mstatus, 64'h1880); // MPIE from MIE, MIE clear
    expect_read("mscratch", addr_mscratch, scratch);
  endtask

  task automatic test_mret();
    logic [63:0] target;
    draw_bits(64, target);
    csr_write(addr_mepc, target);
    csr_write(addr_mstatus, 64'h80);
    mret = 1'b1;
    run_cycle();
    check_value("redirect_valid", got_redirect, 64'd1);
    check_value("redirect_pc", got_target, {target[63:2], 2'b00});
    expect_read("mstatus", addr_mstatus, 64'h1888);
    csr_write(addr_mstatus, 64'h8); // MIE=1, MPIE=0
    mret = 1'b1;
    run_cycle();
    check_value("redirect_pc", got_target, {target[63:2], 2'b00});
    expect_read("mstatus", addr_mstatus, 64'h1880);
  endtask

  task automatic test_interrupts();
    logic [63:0] base;
    logic [63:0] epc;
    draw_bits(64, base);
    base[1:0] = 2'b01; // Vectored mode
    csr_write(addr_mtvec, base);
    base[0] = 1'b0;
    csr_write(addr_mie, 64'h888);
    csr_write(addr_mstatus, 64'h8);
    irq_timer = 1'b1;
    run_cycle();
    run_cycle();
    check_value("redirect_valid", got_redirect, 64'd0); // Pending, but no commit
    draw_bits(64, epc);
    pc     = epc;
    commit = 1'b1;
    run_cycle();
    check_value("redirect_valid", got_redirect, 64'd1);
    check_value("redirect_pc", got_target, base + 64'd28);
    expect_read("mcause", addr_mcause, {1'b1, 63'd7});
    expect_read("mtval", addr_mtval, '0);
    expect_read("mepc", addr_mepc, {epc[63:2], 2'b00});
    commit = 1'b1;
    run_cycle();
    check_value("redirect_valid", got_redirect, 64'd0); // MIE cleared by the trap
    csr_write(addr_mstatus, 64'h8);
    irq_soft = 1'b1;
    irq_ext  = 1'b1;
    run_cycle();
    commit = 1'b1;
    run_cycle();
    check_value("redirect_valid", got_redirect, 64'd1);
    check_value("redirect_pc", got_target, base + 64'd44);
    expect_read("mcause", addr_mcause, {1'b1, 63'd11});
    irq_soft  = 1'b0;
    irq_timer = 1'b0;
    irq_ext   = 1'b0;
  endtask

  task automatic test_mcycle();
    logic [63:0] start;
    draw_bits(64, start);
    csr_write(addr_mcycle, start);
    expect_read("mcycle", addr_mcycle, start);
    expect_read("mcycle", addr_mcycle, start + 64'd1);
  endtask

  initial begin
    rst        = 1'b1;
    csr_req    = '0;
    trap_req   = '0;
    mret       = 1'b0;
    commit     = 1'b0;
    pc         = '0;
    irq_soft   = 1'b0;
    irq_timer  = 1'b0;
    irq_ext    = 1'b0;
    lfsr_state = 32'h81bb8739;
    repeat (5) next_cycle();
    set_req(op_rs, addr_misa, 64'd0, 1'b1);
    mret = 1'b1; // Would redirect outside reset
    run_cycle();
    check_value("rd_data", got_rd, 64'd0); // Read data gated in reset
    check_value("redirect_valid", got_redirect, 64'd0);
    repeat (4) next_cycle();
    rst = 1'b0;
    test_reset_values();
    exercise_reg("mscratch", addr_mscratch, '1);
    exercise_reg("mtvec", addr_mtvec, ~64'h2);
    test_exception();
    test_mret();
    test_interrupts();
    test_mcycle();
    $display("Test completed successfully");
    $finish;
  end

endmodule

//--- csr_unit_checker.sv
// Bound assertions on reset redirect, mip tracking and trap entry of the CSR unit
`timescale 1ns/1ns

module csr_unit_checker
  import csr_pkg::*;
(
  input logic       clk,
  input logic       rst,
  input logic       irq_soft,
  input logic       irq_timer,
  input logic       irq_ext,
  input logic       redirect_valid,
  input csr_state_t csr_state,
  input trap_wr_t   trap_wr
);

  // No fetch redirect while in reset
  redirect_in_reset: assert property (@(posedge clk) rst |-> !redirect_valid)
    else $error("redirect_valid high during reset");

  // Pending bits follow the lines one cycle later
  mip_follows_lines: assert property (@(posedge clk) disable iff (rst)
    1'b1 |=> (csr_state.mip[11] == $past(irq_ext)) && (csr_state.mip[7] == $past(irq_timer))
             && (csr_state.mip[3] == $past(irq_soft)))
    else $error("mip does not match the interrupt lines");

  trap_clears_mie: assert property (@(posedge clk) disable iff (rst)
    trap_wr.enter |=> !csr_state.mstatus.f.mie)
    else $error("mstatus.MIE still set after trap entry");

endmodule

bind csr_unit csr_unit_checker u_checker (
  .clk            (clk),
  .rst            (rst),
  .irq_soft       (irq_soft),
  .irq_timer      (irq_timer),
  .irq_ext        (irq_ext),
  .redirect_valid (redirect_valid),
  .csr_state      (csr_state),
  .trap_wr        (trap_wr)
);

//--- csr_unit.sv
// Machine-mode CSR unit top tying the CSR file, CSR ALU and trap control together
`timescale 1ns/1ns

module csr_unit
  import csr_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  input  csr_req_t        csr_req,
  input  trap_req_t       trap_req,
  input  logic            mret,
  input  logic            commit,
  input  logic [xlen-1:0] pc,
  input  logic            irq_soft,
  input  logic            irq_timer,
  input  logic            irq_ext,
  output logic [xlen-1:0] rd_data,
  output logic            csr_illegal,
  output logic            redirect_valid,
  output logic [xlen-1:0] redirect_pc
);

  csr_state_t      csr_state;
  trap_wr_t        trap_wr;
  logic [xlen-1:0] old_value;
  logic [xlen-1:0] wr_value;
  logic            wr_intent;

  csr_file u_csr_file (
    .clk         (clk),
    .rst         (rst),
    .csr_req     (csr_req),
    .wr_value    (wr_value),
    .wr_intent   (wr_intent),
    .trap_wr     (trap_wr),
    .irq_soft    (irq_soft),
    .irq_timer   (irq_timer),
    .irq_ext     (irq_ext),
    .old_value   (old_value),
    .rd_data     (rd_data),
    .csr_illegal (csr_illegal),
    .csr_state   (csr_state)
  );

  csr_alu u_csr_alu (
    .op        (csr_req.op),
    .old_value (old_value),
    .src       (csr_req.src),
    .src_is_x0 (csr_req.src_is_x0),
    .wr_value  (wr_value),
    .wr_intent (wr_intent)
  );

  trap_ctrl u_trap_ctrl (
    .trap_req       (trap_req),
    .mret           (mret),
    .commit         (commit),
    .pc             (pc),
    .csr_state      (csr_state),
    .rst            (rst),
    .trap_wr        (trap_wr),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc)
  );

endmodule

//--- trap_ctrl.sv
// Trap control choosing exception, mret or interrupt and building the redirect target
`timescale 1ns/1ns

module trap_ctrl
  import csr_pkg::*;
(
  input  trap_req_t       trap_req,
  input  logic            mret,
  input  logic            commit,
  input  logic [xlen-1:0] pc,
  input  csr_state_t      csr_state,
  input  logic            rst,
  output trap_wr_t        trap_wr,
  output logic            redirect_valid,
  output logic [xlen-1:0] redirect_pc
);

  logic [xlen-1:0] pending;
  logic [xlen-1:0] irq_code;
  logic [xlen-1:0] tvec_base;
  logic            irq_any;
  logic            take_exc;
  logic            take_ret;
  logic            take_irq;
  mstatus_u        ms_next;

  // Enabled and pending machine interrupts
  assign pending = csr_state.mie & csr_state.mip;
  assign irq_any = pending[11] | pending[7] | pending[3];

  // External first, then software, then timer
  always_comb begin
    if (pending[11]) begin
      irq_code = cause_mei;
    end else if (pending[3]) begin
      irq_code = cause_msi;
    end else begin
      irq_code = cause_mti;
    end
  end

  // Exception beats mret, mret beats interrupt
  assign take_exc = trap_req.valid;
  assign take_ret = mret & ~take_exc;
  assign take_irq = commit & ~trap_req.valid & ~mret
                  & csr_state.mstatus.f.mie & irq_any;

  // New mstatus on entry or exit
  always_comb begin
    ms_next = csr_state.mstatus;
    if (take_exc || take_irq) begin
      ms_next.f.mpie = csr_state.mstatus.f.mie;
      ms_next.f.mie  = 1'b0;
      ms_next.f.mpp  = priv_m; // No lower modes
    end else if (take_ret) begin
      ms_next.f.mie  = csr_state.mstatus.f.mpie;
      ms_next.f.mpie = 1'b1;
    end
  end

  always_comb begin
    trap_wr.enter   = take_exc | take_irq;
    trap_wr.exit    = take_ret;
    trap_wr.mstatus = ms_next;
    trap_wr.mepc    = pc & mepc_wmask;
    if (take_exc) begin
      trap_wr.mcause = trap_req.cause;
      trap_wr.mtval  = trap_req.tval;
    end else begin
      trap_wr.mcause = cause_irq_flag | irq_code;
      trap_wr.mtval  = '0; // No trap value for interrupts
    end
  end

  assign tvec_base = {csr_state.mtvec[xlen-1:2], 2'b00};

  // Redirect target for fetch
  always_comb begin
    if (take_ret) begin
      redirect_pc = csr_state.mepc;
    end else if (take_irq && csr_state.mtvec[0]) begin
      redirect_pc = tvec_base + (irq_code << 2); // Vectored mode
    end else begin
      redirect_pc = tvec_base;
    end
  end

  assign redirect_valid = ~rst & (trap_wr.enter | trap_wr.exit);

endmodule

//--- csr_alu.sv
// New CSR value for read-write, read-set and read-clear, plus the write intent
`timescale 1ns/1ns

module csr_alu
  import csr_pkg::*;
(
  input  csr_op_e         op,
  input  logic [xlen-1:0] old_value,
  input  logic [xlen-1:0] src,
  input  logic            src_is_x0,
  output logic [xlen-1:0] wr_value,
  output logic            wr_intent
);

  always_comb begin
    case (op)
      op_rw: begin
        wr_value  = src;
        wr_intent = 1'b1;
      end
      op_rs: begin
        wr_value  = old_value | src;
        wr_intent = ~src_is_x0; // csrrs with x0 is a pure read
      end
      op_rc: begin
        wr_value  = old_value & ~src;
        wr_intent = ~src_is_x0;
      end
      default: begin
        // Unused encoding, no write
        wr_value  = old_value;
        wr_intent = 1'b0;
      end
    endcase
  end

endmodule

//--- csr_file.sv
// Machine CSR storage with address decode, illegal access check, read mux and trap updates
`timescale 1ns/1ns

module csr_file
  import csr_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  input  csr_req_t        csr_req,
  input  logic [xlen-1:0] wr_value,
  input  logic            wr_intent,
  input  trap_wr_t        trap_wr,
  input  logic            irq_soft,
  input  logic            irq_timer,
  input  logic            irq_ext,
  output logic [xlen-1:0] old_value,
  output logic [xlen-1:0] rd_data,
  output logic            csr_illegal,
  output csr_state_t      csr_state
);

  logic [xlen-1:0] mstatus_q;
  logic [xlen-1:0] mie_q;
  logic [xlen-1:0] mtvec_q;
  logic [xlen-1:0] mscratch_q;
  logic [xlen-1:0] mepc_q;
  logic [xlen-1:0] mcause_q;
  logic [xlen-1:0] mtval_q;
  logic [xlen-1:0] mip_q;
  logic [xlen-1:0] mcycle_q;
  logic [xlen-1:0] mip_next;

  logic addr_known;
  logic addr_ro;
  logic trap_busy;
  logic csr_we;
  logic we_mstatus;
  logic we_mie;
  logic we_mtvec;
  logic we_mscratch;
  logic we_mepc;
  logic we_mcause;
  logic we_mtval;
  logic we_mcycle;

  // Keep the read-only bits of a register while writing the rest
  function automatic logic [xlen-1:0] merge_wr(input logic [xlen-1:0] cur,
                                               input logic [xlen-1:0] nxt,
                                               input logic [xlen-1:0] mask);
    merge_wr = (cur & ~mask) | (nxt & mask);
  endfunction

  // Address decode and read mux
  always_comb begin
    addr_known = 1'b1;
    addr_ro    = 1'b0;
    old_value  = '0;
    case (csr_req.addr)
      addr_mstatus:  old_value = mstatus_q;
      addr_mie:      old_value = mie_q;
      addr_mtvec:    old_value = mtvec_q;
      addr_mscratch: old_value = mscratch_q;
      addr_mepc:     old_value = mepc_q;
      addr_mcause:   old_value = mcause_q;
      addr_mtval:    old_value = mtval_q;
      addr_mip:      old_value = mip_q;
      addr_mcycle:   old_value = mcycle_q;
      addr_misa: begin
        old_value = misa_value;
        addr_ro   = 1'b1;
      end
      addr_mvendorid, addr_marchid, addr_mimpid, addr_mhartid: begin
        addr_ro = 1'b1; // IDs read as zero
      end
      default: addr_known = 1'b0;
    endcase
  end

  assign csr_illegal = csr_req.valid & (~addr_known | (addr_ro & wr_intent));
  assign rd_data     = (rst || !csr_req.valid) ? '0 : old_value;

  // A trap entry or exit cancels the CSR write of the same cycle
  assign trap_busy = trap_wr.enter | trap_wr.exit;
  assign csr_we    = csr_req.valid & wr_intent & ~csr_illegal & ~trap_busy;

  assign we_mstatus  = csr_we & (csr_req.addr == addr_mstatus);
  assign we_mie      = csr_we & (csr_req.addr == addr_mie);
  assign we_mtvec    = csr_we & (csr_req.addr == addr_mtvec);
  assign we_mscratch = csr_we & (csr_req.addr == addr_mscratch);
  assign we_mepc     = csr_we & (csr_req.addr == addr_mepc);
  assign we_mcause   = csr_we & (csr_req.addr == addr_mcause);
  assign we_mtval    = csr_we & (csr_req.addr == addr_mtval);
  assign we_mcycle   = csr_we & (csr_req.addr == addr_mcycle);

  // Pending bits follow the lines MEIP, MTIP, MSIP
  assign mip_next = {52'b0, irq_ext, 3'b0, irq_timer, 3'b0, irq_soft, 3'b0};

  // Trap side registers, trap update wins over a CSR write
  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus_q <= mstatus_reset;
      mepc_q    <= '0;
      mcause_q  <= '0;
      mtval_q   <= '0;
    end else if (trap_wr.enter) begin
      mstatus_q <= trap_wr.mstatus.raw;
      mepc_q    <= trap_wr.mepc;
      mcause_q  <= trap_wr.mcause;
      mtval_q   <= trap_wr.mtval;
    end else if (trap_wr.exit) begin
      mstatus_q <= trap_wr.mstatus.raw; // mret only touches mstatus
    end else begin
      if (we_mstatus) mstatus_q <= merge_wr(mstatus_q, wr_value, mstatus_wmask);
      if (we_mepc)    mepc_q    <= merge_wr(mepc_q, wr_value, mepc_wmask);
      if (we_mcause)  mcause_q  <= wr_value;
      if (we_mtval)   mtval_q   <= wr_value;
    end
  end

  // Plain software registers
  always_ff @(posedge clk) begin
    if (rst) begin
      mie_q      <= '0;
      mtvec_q    <= '0;
      mscratch_q <= '0;
      mip_q      <= '0;
    end else begin
      if (we_mie)      mie_q      <= merge_wr(mie_q, wr_value, mie_wmask);
      if (we_mtvec)    mtvec_q    <= merge_wr(mtvec_q, wr_value, mtvec_wmask);
      if (we_mscratch) mscratch_q <= wr_value;
      mip_q <= mip_next; // Writes to mip are dropped
    end
  end

  // Free running cycle counter
  always_ff @(posedge clk) begin
    if (rst) begin
      mcycle_q <= '0;
    end else if (we_mcycle) begin
      mcycle_q <= wr_value;
    end else begin
      mcycle_q <= mcycle_q + 64'd1;
    end
  end

  assign csr_state.mstatus.raw = mstatus_q;
  assign csr_state.mtvec       = mtvec_q;
  assign csr_state.mepc        = mepc_q;
  assign csr_state.mie         = mie_q;
  assign csr_state.mip         = mip_q;

endmodule

//--- csr_pkg.sv
// Shared widths, CSR map, reset values, masks and bundle types for the machine CSR unit
package csr_pkg;

  localparam int xlen = 64;

  // Machine CSR addresses
  localparam logic [11:0] addr_mstatus   = 12'h300;
  localparam logic [11:0] addr_misa      = 12'h301;
  localparam logic [11:0] addr_mie       = 12'h304;
  localparam logic [11:0] addr_mtvec     = 12'h305;
  localparam logic [11:0] addr_mscratch  = 12'h340;
  localparam logic [11:0] addr_mepc      = 12'h341;
  localparam logic [11:0] addr_mcause    = 12'h342;
  localparam logic [11:0] addr_mtval     = 12'h343;
  localparam logic [11:0] addr_mip       = 12'h344;
  localparam logic [11:0] addr_mcycle    = 12'hb00;
  localparam logic [11:0] addr_mvendorid = 12'hf11;
  localparam logic [11:0] addr_marchid   = 12'hf12;
  localparam logic [11:0] addr_mimpid    = 12'hf13;
  localparam logic [11:0] addr_mhartid   = 12'hf14;

  localparam logic [xlen-1:0] mstatus_reset = 64'h0000_0000_0000_1880; // MPP=M, MPIE=1
  localparam logic [xlen-1:0] misa_value    = 64'h8000_0000_0000_0100; // RV64, base I only
  localparam logic [1:0]      priv_m        = 2'b11;

  // Writable bits per register
  localparam logic [xlen-1:0] mstatus_wmask = 64'h0000_0000_0000_0088; // MIE, MPIE
  localparam logic [xlen-1:0] mie_wmask     = 64'h0000_0000_0000_0888; // MSIE, MTIE, MEIE
  localparam logic [xlen-1:0] mtvec_wmask   = 64'hffff_ffff_ffff_fffd; // Bit 1 reserved
  localparam logic [xlen-1:0] mepc_wmask    = 64'hffff_ffff_ffff_fffc;

  // Interrupt cause codes
  localparam logic [xlen-1:0] cause_msi      = 64'd3;
  localparam logic [xlen-1:0] cause_mti      = 64'd7;
  localparam logic [xlen-1:0] cause_mei      = 64'd11;
  localparam logic [xlen-1:0] cause_irq_flag = 64'h8000_0000_0000_0000;

  // Encoded like funct3[1:0] of the CSR instructions
  typedef enum logic [1:0] {
    op_rw = 2'b01,
    op_rs = 2'b10,
    op_rc = 2'b11
  } csr_op_e;

  typedef struct packed {
    logic            valid;
    csr_op_e         op;
    logic [11:0]     addr;
    logic [xlen-1:0] src;
    logic            src_is_x0;
  } csr_req_t;

  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] cause;
    logic [xlen-1:0] tval;
  } trap_req_t;

  // mstatus fields, machine mode only
  typedef struct packed {
    logic [63:13] rsv_hi;
    logic [1:0]   mpp;    // Bits 12:11
    logic [10:8]  rsv_mid;
    logic         mpie;   // Bit 7
    logic [6:4]   rsv_lo;
    logic         mie;    // Bit 3
    logic [2:0]   rsv_low;
  } mstatus_f_t;

  typedef union packed {
    logic [xlen-1:0] raw;
    mstatus_f_t      f;
  } mstatus_u;

  // Register view handed to the trap control
  typedef struct packed {
    mstatus_u        mstatus;
    logic [xlen-1:0] mtvec;
    logic [xlen-1:0] mepc;
    logic [xlen-1:0] mie;
    logic [xlen-1:0] mip;
  } csr_state_t;

  // Trap entry or exit update
  typedef struct packed {
    logic            enter;
    logic            exit;
    mstatus_u        mstatus;
    logic [xlen-1:0] mepc;
    logic [xlen-1:0] mcause;
    logic [xlen-1:0] mtval;
  } trap_wr_t;

endpackage
